// File: verilog/st_glue_params.svh
/*
 * ST glue constants
 * clock rates, reset window, MFP divider, timer-A delay and RTC year fix
 */
`ifndef ST_GLUE_PARAMS_SVH
`define ST_GLUE_PARAMS_SVH

// system and MFP clocks in Hz
`define ST_SYSTEM_CLOCK_HZ 32084988
`define ST_MFP_CLOCK_HZ 2457600

// reset counter reload, counts down to 0
`define ST_RESET_CYCLES 127

// MCU reset window on the counter
`define ST_MCU_RESET_ASSERT 10
`define ST_MCU_RESET_RELEASE 8

// 2 MHz enable period in clk_32 cycles
`define ST_CLK2_DIV 16

// STe timer-A delay, 74LS164 equivalent
`define ST_TAI_DELAY_STAGES 8

// added to year units, year 0 read as 1980
`define ST_RTC_YEAR_OFFSET 2

`endif

// File: verilog/st_rtc_pkg.sv
/*
 * RP5C15 RTC types
 * host time word with field and digit views, register indices
 */
package st_rtc_pkg;

	// time word as BCD fields, msb first
	typedef struct packed {
		logic [3:0] dow;    // day of week
		logic [7:0] year;   // tens, units
		logic [7:0] month;
		logic [7:0] day;
		logic [7:0] hour;
		logic [7:0] minute;
		logic [7:0] second; // units in [3:0]
	} rtc_fields_t;

	// same word as 13 nibbles, digit 0 = second units, digit 12 = day of week
	typedef logic [12:0][3:0] rtc_digits_t;

	typedef union packed {
		rtc_fields_t fields;
		rtc_digits_t digits;
	} rtc_time_t;

	// register indices with special meaning
	typedef enum logic [3:0] {
		RTC_REG_DOW        = 4'd6,  // day of week sits between hour and day
		RTC_REG_YEAR_UNITS = 4'd11,
		RTC_REG_YEAR_TENS  = 4'd12,
		RTC_REG_BANK       = 4'd13, // mode register, bit 0 = bank
		RTC_REG_TEST       = 4'd14,
		RTC_REG_ID         = 4'd15  // reset / id
	} rtc_reg_e;

endpackage

// File: verilog/st_audio_pkg.sv
/*
 * audio sample types
 * YM and DMA-sound inputs, signed mix output
 */
package st_audio_pkg;

	// YM2149 combined output, offset binary
	typedef logic [9:0] ym_sample_t;

	// STe DMA sound, one channel, offset binary
	typedef logic [7:0] dma_sample_t;

	// mixer output for the sigma-delta DAC
	typedef logic signed [14:0] mix_sample_t;

endpackage

// File: verilog/st_reset_seq.sv
/*
 * reset sequencer
 * power-on counter, system and peripheral reset, MCU reset pulse
 */
`timescale 1ns/1ps
`include "st_glue_params.svh"

module st_reset_seq (
	input  logic clk_32,
	input  logic xsint,
	input  logic ext_reset_n_i,
	input  logic cpu_reset_n_i,  // CPU reset output
	output logic reset_o,
	output logic peripheral_reset_o,
	output logic mcu_reset_n_o
);

	logic [6:0] reset_cnt;
	logic       cpu_reset_n_d;  // previous CPU reset level
	logic       cpu_reset_fall;

	// CPU executed RESET instruction
	assign cpu_reset_fall = cpu_reset_n_d & ~cpu_reset_n_i;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			reset_cnt          <= 7'(`ST_RESET_CYCLES);
			reset_o            <= 1'b1;
			peripheral_reset_o <= 1'b1;
			mcu_reset_n_o      <= 1'b1;
			cpu_reset_n_d      <= 1'b1;
		end else begin
			cpu_reset_n_d      <= cpu_reset_n_i;
			reset_o            <= reset_cnt != '0;
			peripheral_reset_o <= reset_o | ~cpu_reset_n_i;

			if (!ext_reset_n_i)
				reset_cnt <= 7'(`ST_RESET_CYCLES); // restart the whole sequence
			else if (reset_cnt != '0)
				reset_cnt <= reset_cnt - 7'd1;

			// MCU only held briefly, its clocks feed the SDRAM side
			if (cpu_reset_fall)
				mcu_reset_n_o <= 1'b0;
			else if (reset_cnt == 7'(`ST_MCU_RESET_ASSERT))
				mcu_reset_n_o <= 1'b0;
			else if (reset_cnt < 7'(`ST_MCU_RESET_RELEASE))
				mcu_reset_n_o <= 1'b1;
		end
	end

	// below the window only the CPU edge may pull the MCU reset
	a_mcu_window: assert property (@(posedge clk_32) disable iff (!xsint)
		(!mcu_reset_n_o && reset_cnt < 7'(`ST_MCU_RESET_RELEASE - 1))
			|-> $past(cpu_reset_fall))
		else $error("mcu reset low outside window");

endmodule

// File: verilog/st_mfp_timing.sv
/*
 * MFP timing helpers
 * fractional 2.4576 MHz clock, 2 MHz enable, STe timer-A delay, GPIO7
 */
`timescale 1ns/1ps
`include "st_glue_params.svh"

module st_mfp_timing (
	input  logic clk_32,
	input  logic xsint,
	input  logic ste_i,
	input  logic mono_detect_i,   // low for monochrome
	input  logic dma_snd_int_i,   // DMA sound interrupt, high active
	output logic mfp_clk_o,
	output logic mfp_tai_o,
	output logic mfp_io7_o,
	output logic clk2_en_o
);

	localparam logic [31:0] HALF_SYS = 32'(`ST_SYSTEM_CLOCK_HZ / 2);
	localparam logic [31:0] MFP_STEP = 32'(`ST_MFP_CLOCK_HZ);
	localparam int CLK2_W = $clog2(`ST_CLK2_DIV);
	localparam logic [CLK2_W-1:0] CLK2_LAST = CLK2_W'(`ST_CLK2_DIV - 1);
	localparam int TAI_N = `ST_TAI_DELAY_STAGES;

	logic [31:0]       mfp_acc;    // phase accumulator
	logic [CLK2_W-1:0] clk2_cnt;
	logic [TAI_N-1:0]  tai_delay;  // shift register, ones walk in

	// half period of the MFP clock per wrap
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mfp_acc   <= '0;
			mfp_clk_o <= 1'b0;
		end else if (mfp_acc < HALF_SYS) begin
			mfp_acc <= mfp_acc + MFP_STEP;
		end else begin
			mfp_acc   <= mfp_acc - (HALF_SYS - MFP_STEP); // keep the remainder
			mfp_clk_o <= ~mfp_clk_o;
		end
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			clk2_cnt  <= '0;
			clk2_en_o <= 1'b0;
		end else begin
			clk2_en_o <= clk2_cnt == CLK2_LAST; // new count is 0
			if (clk2_cnt == CLK2_LAST)
				clk2_cnt <= '0;
			else
				clk2_cnt <= clk2_cnt + 1'b1;
		end
	end

	// about 4 us delay before timer A sees the end of the interrupt
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			tai_delay <= '0;
		else if (dma_snd_int_i)
			tai_delay <= '0; // interrupt active, flush line
		else if (clk2_en_o)
			tai_delay <= {tai_delay[TAI_N-2:0], 1'b1};
	end

	assign mfp_tai_o = ste_i & tai_delay[TAI_N-1]; // ST uses printer busy instead

	// STe: mono detect xor'd with DMA sound interrupt
	assign mfp_io7_o = mono_detect_i ^ (ste_i & ~dma_snd_int_i);

	a_acc_bound: assert property (@(posedge clk_32) disable iff (!xsint)
		mfp_acc <= HALF_SYS + MFP_STEP)
		else $error("mfp accumulator out of range");

endmodule

// File: verilog/st_rtc.sv
/*
 * RP5C15 real-time clock register model
 * time digits from the host word, scratch RAM in bank 1, Wishbone classic slave
 */
`timescale 1ns/1ps
`include "st_glue_params.svh"

module st_rtc (
	input  logic                  clk_32,
	input  logic                  xsint,
	input  logic                  peripheral_reset_i,
	input  st_rtc_pkg::rtc_time_t rtc_time_i,
	input  logic                  rtc_cyc_i,
	input  logic                  rtc_stb_i,
	input  logic                  rtc_we_i,
	input  logic [3:0]            rtc_adr_i,
	input  logic [3:0]            rtc_dat_i,
	output logic                  rtc_ack_o,
	output logic [3:0]            rtc_dat_o
);

	import st_rtc_pkg::*;

	logic        wb_req;        // new access this cycle
	logic        rtc_bank;
	logic [3:0]  scratch_ram [16];
	logic [3:0]  rd_data;
	rtc_digits_t time_digits;

	assign wb_req      = rtc_cyc_i & rtc_stb_i & ~rtc_ack_o;
	assign time_digits = rtc_time_i.digits;

	// one ack per request, never stalls
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			rtc_ack_o <= 1'b0;
		else
			rtc_ack_o <= wb_req;
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			rtc_bank <= 1'b0;
		else if (peripheral_reset_i)
			rtc_bank <= 1'b0;
		else if (wb_req && rtc_we_i && rtc_adr_i == RTC_REG_BANK)
			rtc_bank <= rtc_dat_i[0];
	end

	// all other indices land in RAM, even in bank 0
	always_ff @(posedge clk_32) begin
		if (wb_req && rtc_we_i && rtc_adr_i != RTC_REG_BANK)
			scratch_ram[rtc_adr_i] <= rtc_dat_i;
	end

	// read decode, RP5C15 register order
	always_comb begin
		rd_data = 4'hf;
		case (rtc_adr_i)
			RTC_REG_BANK: rd_data = {1'b1, 2'b00, rtc_bank};
			RTC_REG_TEST: rd_data = 4'h0;
			RTC_REG_ID:   rd_data = 4'hc;
			default: begin
				if (rtc_bank)
					rd_data = scratch_ram[rtc_adr_i];
				else if (rtc_adr_i == RTC_REG_DOW)
					rd_data = time_digits[12];
				else if (rtc_adr_i == RTC_REG_YEAR_UNITS)
					// GEMDOS counts from 1980
					rd_data = rtc_time_i.fields.year[3:0] + 4'(`ST_RTC_YEAR_OFFSET);
				else if (rtc_adr_i > RTC_REG_DOW)
					rd_data = time_digits[rtc_adr_i - 4'd1]; // skip past dow slot
				else
					rd_data = time_digits[rtc_adr_i];  // sec, min, hour
			end
		endcase
		// no time from the host yet, RTC looks absent
		if (rtc_time_i == '0)
			rd_data = 4'hf;
	end

	// data held for the ack cycle
	always_ff @(posedge clk_32) begin
		if (wb_req)
			rtc_dat_o <= rd_data;
	end

	a_ack_single: assert property (@(posedge clk_32) disable iff (!xsint)
		rtc_ack_o |=> !rtc_ack_o)
		else $error("rtc ack held two cycles");

	// master keeps stb up until it sees ack
	a_ack_stb: assert property (@(posedge clk_32) disable iff (!xsint)
		rtc_ack_o |-> rtc_stb_i)
		else $error("rtc ack without stb");

endmodule

// File: verilog/st_audio_mix.sv
/*
 * audio mixer
 * YM and DMA sound widened to 14 bits, summed to 15-bit signed per channel
 */
`timescale 1ns/1ps

module st_audio_mix (
	input  logic                      clk_32,
	input  logic                      xsint,
	input  st_audio_pkg::ym_sample_t  ym_sample_i,
	input  st_audio_pkg::dma_sample_t dma_snd_l_i,
	input  st_audio_pkg::dma_sample_t dma_snd_r_i,
	output st_audio_pkg::mix_sample_t audio_l_o,
	output st_audio_pkg::mix_sample_t audio_r_o
);

	import st_audio_pkg::*;

	ym_sample_t  ym_signed;   // offset removed, two's complement
	logic [13:0] ym_wide;
	mix_sample_t ym_ext;

	// offset removal and widening, fraction from the top bits
	function automatic mix_sample_t dma_ext(input dma_sample_t s);
		dma_sample_t v;
		logic [13:0] w;
		v = s - 8'h80;
		w = {v, v[7:2]};
		return {w[13], w};
	endfunction

	assign ym_signed = ym_sample_i - 10'h200;
	assign ym_wide   = {ym_signed, ym_signed[9:6]};
	assign ym_ext    = {ym_wide[13], ym_wide};

	// YM is mono, same on both sides
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			audio_l_o <= '0;
			audio_r_o <= '0;
		end else begin
			audio_l_o <= ym_ext + dma_ext(dma_snd_l_i); // two 14 bit terms, no overflow
			audio_r_o <= ym_ext + dma_ext(dma_snd_r_i);
		end
	end

endmodule

// File: verilog/st_glue_top.sv
/*
 * ST/STe board glue
 * reset sequencing, MFP timing, RTC model and audio mix
 */
`timescale 1ns/1ps

module st_glue_top (
	input  logic                      clk_32,
	input  logic                      xsint,
	// resets
	input  logic                      ext_reset_n_i,
	input  logic                      cpu_reset_n_i,
	output logic                      reset_o,
	output logic                      peripheral_reset_o,
	output logic                      mcu_reset_n_o,
	// MFP side
	input  logic                      ste_i,
	input  logic                      mono_detect_i,
	input  logic                      dma_snd_int_i,
	output logic                      mfp_clk_o,
	output logic                      mfp_tai_o,
	output logic                      mfp_io7_o,
	output logic                      clk2_en_o,
	// RTC host port
	input  st_rtc_pkg::rtc_time_t     rtc_time_i,
	input  logic                      rtc_cyc_i,
	input  logic                      rtc_stb_i,
	input  logic                      rtc_we_i,
	input  logic [3:0]                rtc_adr_i,
	input  logic [3:0]                rtc_dat_i,
	output logic                      rtc_ack_o,
	output logic [3:0]                rtc_dat_o,
	// audio
	input  st_audio_pkg::ym_sample_t  ym_sample_i,
	input  st_audio_pkg::dma_sample_t dma_snd_l_i,
	input  st_audio_pkg::dma_sample_t dma_snd_r_i,
	output st_audio_pkg::mix_sample_t audio_l_o,
	output st_audio_pkg::mix_sample_t audio_r_o
);

	st_reset_seq u_reset_seq (
		.clk_32             (clk_32),
		.xsint              (xsint),
		.ext_reset_n_i      (ext_reset_n_i),
		.cpu_reset_n_i      (cpu_reset_n_i),
		.reset_o            (reset_o),
		.peripheral_reset_o (peripheral_reset_o),
		.mcu_reset_n_o      (mcu_reset_n_o)
	);

	st_mfp_timing u_mfp_timing (
		.clk_32        (clk_32),
		.xsint         (xsint),
		.ste_i         (ste_i),
		.mono_detect_i (mono_detect_i),
		.dma_snd_int_i (dma_snd_int_i),
		.mfp_clk_o     (mfp_clk_o),
		.mfp_tai_o     (mfp_tai_o),
		.mfp_io7_o     (mfp_io7_o),
		.clk2_en_o     (clk2_en_o)
	);

	st_rtc u_rtc (
		.clk_32             (clk_32),
		.xsint              (xsint),
		.peripheral_reset_i (peripheral_reset_o), // clears the bank bit
		.rtc_time_i         (rtc_time_i),
		.rtc_cyc_i          (rtc_cyc_i),
		.rtc_stb_i          (rtc_stb_i),
		.rtc_we_i           (rtc_we_i),
		.rtc_adr_i          (rtc_adr_i),
		.rtc_dat_i          (rtc_dat_i),
		.rtc_ack_o          (rtc_ack_o),
		.rtc_dat_o          (rtc_dat_o)
	);

	st_audio_mix u_audio_mix (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.ym_sample_i (ym_sample_i),
		.dma_snd_l_i (dma_snd_l_i),
		.dma_snd_r_i (dma_snd_r_i),
		.audio_l_o   (audio_l_o),
		.audio_r_o   (audio_r_o)
	);

endmodule

// File: verification/st_glue_checker.sv
/*
 * ST glue checker
 * reference models of reset, MFP, RTC and audio rules, compared every falling edge
 */
`timescale 1ns/1ps
`include "st_glue_params.svh"

module st_glue_checker (
	input  logic                      clk_32, xsint, ext_reset_n_i, cpu_reset_n_i,
	input  logic                      reset_o, peripheral_reset_o, mcu_reset_n_o,
	input  logic                      ste_i, mono_detect_i, dma_snd_int_i,
	input  logic                      mfp_clk_o, mfp_tai_o, mfp_io7_o, clk2_en_o,
	input  st_rtc_pkg::rtc_time_t     rtc_time_i,
	input  logic                      rtc_we_i, rtc_ack_o,
	input  logic [3:0]                rtc_adr_i, rtc_dat_i, rtc_dat_o,
	input  st_audio_pkg::ym_sample_t  ym_sample_i,
	input  st_audio_pkg::dma_sample_t dma_snd_l_i, dma_snd_r_i,
	input  st_audio_pkg::mix_sample_t audio_l_o, audio_r_o,
	output int                        mismatch_count_o
);

	import st_rtc_pkg::*;
	import st_audio_pkg::*;

	localparam int HALF_SYS = `ST_SYSTEM_CLOCK_HZ / 2;
	// 8 shifts, first one waits up to a whole enable period
	localparam int TAI_MIN = (`ST_TAI_DELAY_STAGES - 1) * `ST_CLK2_DIV + 1;
	localparam int TAI_MAX = `ST_TAI_DELAY_STAGES * `ST_CLK2_DIV;

	int          edges;      // rising edges since xsint release
	int          tai_wait;   // edges since the sound interrupt fell
	int          acc;        // MFP phase accumulator
	int          rst_cnt;
	logic        rst, prst, mcu_n, cpu_n_d, mfp_clk;
	logic        int_d, tai_d, por_seen, rtc_bank;
	logic [3:0]  rtc_ram [16];
	mix_sample_t exp_l, exp_r;  // from last cycle's samples

	initial mismatch_count_o = 0;

	function automatic int next_reset_count(input int cnt, input logic ext_n);
		if (!ext_n)
			return `ST_RESET_CYCLES; // reload
		return (cnt > 0) ? cnt - 1 : 0;
	endfunction

	// add below half the system rate, else wrap and toggle
	function automatic int next_mfp_acc(input int a);
		return (a < HALF_SYS) ? a + `ST_MFP_CLOCK_HZ : a - (HALF_SYS - `ST_MFP_CLOCK_HZ);
	endfunction

	// STe with the sound interrupt idle inverts the monitor detect line
	function automatic logic io7_expect(input logic mono, input logic ste, input logic irq);
		if (ste && !irq)
			return ~mono;
		return mono;
	endfunction

	function automatic logic [3:0] rtc_expect(input logic [3:0] adr, input rtc_time_t t);
		rtc_fields_t f;
		logic [3:0]  dig [13];
		logic [3:0]  d;
		f = t.fields;
		dig = '{f.second[3:0], f.second[7:4], f.minute[3:0], f.minute[7:4], f.hour[3:0],
			f.hour[7:4], f.dow, f.day[3:0], f.day[7:4], f.month[3:0], f.month[7:4],
			f.year[3:0] + 4'(`ST_RTC_YEAR_OFFSET), f.year[7:4]};
		if (adr < 4'd13)
			d = rtc_bank ? rtc_ram[adr] : dig[adr];
		else if (adr == 4'd13)
			d = {3'b100, rtc_bank}; // 8 plus bank
		else
			d = (adr == 4'd14) ? 4'h0 : 4'hc;
		if (t == '0)
			d = 4'hf; // no time word, reads as absent
		return d;
	endfunction

	// minus offset is an msb flip, then widen with the top bits
	function automatic mix_sample_t mix_expect(input ym_sample_t ym, input dma_sample_t dma);
		logic signed [13:0] y;
		logic signed [13:0] d;
		y = {~ym[9], ym[8:0], ~ym[9], ym[8:6]};
		d = {~dma[7], dma[6:0], ~dma[7], dma[6:2]};
		return mix_sample_t'(int'(y) + int'(d));
	endfunction

	task automatic compare_value(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp) begin
			mismatch_count_o++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	always @(negedge clk_32) begin
		if (!xsint) begin
			edges    = -1;
			tai_wait = -1;
			rst_cnt  = `ST_RESET_CYCLES;
			{rst, prst, mcu_n, cpu_n_d} = 4'b1111;
			{acc, mfp_clk} = '0;
			{int_d, tai_d, por_seen, rtc_bank} = 4'b1000;
			exp_l    = '0;
			exp_r    = '0;
		end else begin
			edges++;
			tai_wait = dma_snd_int_i ? -1 : tai_wait + 1;
			compare_value("reset_o", reset_o, rst);
			compare_value("peripheral_reset_o", peripheral_reset_o, prst);
			compare_value("mcu_reset_n_o", mcu_reset_n_o, mcu_n);
			if (!por_seen && !reset_o) begin
				por_seen = 1'b1;
				compare_value("edges to reset_o release", edges, `ST_RESET_CYCLES + 1);
			end
			compare_value("mfp_clk_o", mfp_clk_o, mfp_clk);
			compare_value("clk2_en_o", clk2_en_o, edges > 0 && edges % `ST_CLK2_DIV == 0);
			compare_value("mfp_io7_o", mfp_io7_o,
				io7_expect(mono_detect_i, ste_i, dma_snd_int_i));
			if (int_d || !ste_i)
				compare_value("mfp_tai_o", mfp_tai_o, 1'b0); // cleared or masked
			if (mfp_tai_o && !tai_d)
				compare_value($sformatf("mfp_tai_o rose %0d edges after interrupt", tai_wait),
					tai_wait >= TAI_MIN && tai_wait <= TAI_MAX, 1'b1);
			compare_value("audio_l_o", audio_l_o, exp_l);
			compare_value("audio_r_o", audio_r_o, exp_r);
			if (rtc_ack_o && !rtc_we_i)
				compare_value($sformatf("rtc_dat_o reg %0d", rtc_adr_i), rtc_dat_o,
					rtc_expect(rtc_adr_i, rtc_time_i));

			// reset sequencer, old counter decides
			prst = rst | ~cpu_reset_n_i;
			rst  = rst_cnt != 0;
			if (cpu_n_d && !cpu_reset_n_i)
				mcu_n = 1'b0; // RESET instruction pulse
			else if (rst_cnt == `ST_MCU_RESET_ASSERT)
				mcu_n = 1'b0;
			else if (rst_cnt < `ST_MCU_RESET_RELEASE)
				mcu_n = 1'b1;
			rst_cnt = next_reset_count(rst_cnt, ext_reset_n_i);
			cpu_n_d = cpu_reset_n_i;
			if (acc >= HALF_SYS)
				mfp_clk = ~mfp_clk;
			acc = next_mfp_acc(acc);
			// writes land on the ack edge
			if (rtc_ack_o && rtc_we_i && rtc_adr_i == 4'd13)
				rtc_bank = rtc_dat_i[0];
			else if (rtc_ack_o && rtc_we_i)
				rtc_ram[rtc_adr_i] = rtc_dat_i;
			if (peripheral_reset_o)
				rtc_bank = 1'b0;
			exp_l = mix_expect(ym_sample_i, dma_snd_l_i);
			exp_r = mix_expect(ym_sample_i, dma_snd_r_i);
			int_d = dma_snd_int_i;
			tai_d = mfp_tai_o;
		end
	end

endmodule

// File: verification/tb_st_glue.sv
/*
 * ST glue testbench
 * clock, reset, watchdog and stimulus, checking sits in st_glue_checker
 */
`timescale 1ns/1ps

module tb_st_glue;

	import st_rtc_pkg::*;
	import st_audio_pkg::*;

	localparam int CLK_NS      = 40;
	localparam int MFP_CYCLES  = 20000;
	localparam int RESET_PHASE = 8 + 2 * 160 + 40;  // power-on, ext reset, CPU reset
	localparam int RTC_PHASE   = 64 * 10;           // 64 accesses, worst case wait
	localparam int TAI_PHASE   = 2 * 220 + 30;
	localparam int TEST_CYCLES = RESET_PHASE + MFP_CYCLES + 500 + TAI_PHASE + RTC_PHASE;
	localparam int WATCHDOG_NS = TEST_CYCLES * CLK_NS * 12 / 10; // 20 % margin

	logic        clk_32, xsint, ext_reset_n_i, cpu_reset_n_i;
	logic        ste_i, mono_detect_i, dma_snd_int_i;
	logic        rtc_cyc_i, rtc_stb_i, rtc_we_i, rtc_ack_o;
	logic [3:0]  rtc_adr_i, rtc_dat_i, rtc_dat_o;
	logic        reset_o, peripheral_reset_o, mcu_reset_n_o;
	logic        mfp_clk_o, mfp_tai_o, mfp_io7_o, clk2_en_o;
	rtc_time_t   rtc_time_i;
	ym_sample_t  ym_sample_i;
	dma_sample_t dma_snd_l_i, dma_snd_r_i;
	mix_sample_t audio_l_o, audio_r_o;
	int          seed, mismatches, tb_errors;

	st_glue_top uut (.*);
	st_glue_checker chk (.mismatch_count_o(mismatches), .*);

	initial begin
		clk_32 = 1'b0;
		forever #(CLK_NS / 2) clk_32 = ~clk_32;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run did not end within %0d ns", WATCHDOG_NS);
		$display("Finished with errors");
		$finish;
	end

	// n rising edges, then drive slot
	task automatic step_clocks(input int n);
		repeat (n) @(posedge clk_32);
		#2;
	endtask

	task automatic wait_reset_release(input int limit);
		int n;
		n = 0;
		while (reset_o && n < limit) begin
			@(negedge clk_32);
			n++;
		end
		if (reset_o) begin
			$display("reset_o still high after %0d cycles", limit);
			tb_errors++;
		end
	endtask

	// one classic Wishbone cycle, stb held until ack
	task automatic wb_access(input logic we, input logic [3:0] adr, input logic [3:0] dat);
		int n;
		n = 0;
		step_clocks(1);
		rtc_cyc_i = 1'b1;
		rtc_stb_i = 1'b1;
		rtc_we_i  = we;
		rtc_adr_i = adr;
		rtc_dat_i = dat;
		@(negedge clk_32);
		while (!rtc_ack_o && n < 8) begin
			@(negedge clk_32);
			n++;
		end
		if (!rtc_ack_o) begin
			$display("no ack from RTC for register %0d", adr);
			tb_errors++;
		end
		step_clocks(1);
		rtc_cyc_i = 1'b0;
		rtc_stb_i = 1'b0;
		rtc_we_i  = 1'b0;
	endtask

	initial begin
		int n;
		seed = 29;
		tb_errors = 0;
		{xsint, ext_reset_n_i, cpu_reset_n_i} = 3'b011;
		{ste_i, mono_detect_i, dma_snd_int_i} = 3'b111;  // delay line held clear
		{rtc_cyc_i, rtc_stb_i, rtc_we_i, rtc_adr_i, rtc_dat_i} = '0;
		rtc_time_i  = '0;
		ym_sample_i = 10'h200;  // mid scale
		dma_snd_l_i = 8'h80;
		dma_snd_r_i = 8'h80;
		step_clocks(8);
		xsint = 1'b1;

		wait_reset_release(160);
		step_clocks(20);
		ext_reset_n_i = 1'b0;  // reload mid-run
		step_clocks(1);
		ext_reset_n_i = 1'b1;
		step_clocks(2);
		wait_reset_release(160);
		step_clocks(10);
		cpu_reset_n_i = 1'b0;  // RESET instruction
		step_clocks(3);
		cpu_reset_n_i = 1'b1;
		step_clocks(MFP_CYCLES);  // MFP clock runs unattended

		repeat (500) begin
			step_clocks(1);
			ym_sample_i = 10'($random(seed));
			dma_snd_l_i = 8'($random(seed));
			dma_snd_r_i = 8'($random(seed));
		end

		// timer A, STe on
		step_clocks(1);
		dma_snd_int_i = 1'b0;
		n = 0;
		while (!mfp_tai_o && n < 200) begin
			@(negedge clk_32);
			n++;
		end
		if (!mfp_tai_o) begin
			$display("mfp_tai_o did not rise after the interrupt ended");
			tb_errors++;
		end
		step_clocks(1);
		dma_snd_int_i = 1'b1;
		step_clocks(4);
		ste_i = 1'b0;  // plain ST, no timer A path
		step_clocks(1);
		dma_snd_int_i = 1'b0;
		step_clocks(200);
		dma_snd_int_i = 1'b1;
		step_clocks(4);
		for (int i = 0; i < 8; i++) begin
			{mono_detect_i, ste_i, dma_snd_int_i} = 3'(i) ^ 3'b001;
			step_clocks(2);
		end
		dma_snd_int_i = 1'b1;

		// RTC bank 0, then no time word, then scratch RAM in bank 1
		rtc_time_i = 52'({$random(seed), $random(seed)});
		for (int a = 0; a < 16; a++)
			wb_access(1'b0, 4'(a), 4'h0);
		rtc_time_i = '0;
		for (int a = 0; a < 16; a++)
			wb_access(1'b0, 4'(a), 4'h0);
		rtc_time_i = 52'({$random(seed), $random(seed)});
		for (int a = 0; a < 13; a++)
			wb_access(1'b1, 4'(a), 4'($random(seed)));
		wb_access(1'b1, 4'd13, 4'h1);
		for (int a = 0; a < 16; a++)
			wb_access(1'b0, 4'(a), 4'h0);
		cpu_reset_n_i = 1'b0;  // peripheral reset drops the bank bit
		step_clocks(3);
		cpu_reset_n_i = 1'b1;
		step_clocks(4);
		wb_access(1'b0, 4'd13, 4'h0);
		wb_access(1'b0, 4'd0, 4'h0);
		step_clocks(4);

		$display("errors: %0d value mismatches, %0d other failures", mismatches, tb_errors);
		if (mismatches == 0 && tb_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: sources.f
+incdir+verilog
verilog/st_rtc_pkg.sv
verilog/st_audio_pkg.sv
verilog/st_reset_seq.sv
verilog/st_mfp_timing.sv
verilog/st_rtc.sv
verilog/st_audio_mix.sv
verilog/st_glue_top.sv
verification/st_glue_checker.sv
verification/tb_st_glue.sv

// File: Makefile
# Verilator flow for the ST glue testbench

VERILATOR ?= verilator
TOP       ?= tb_st_glue
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= Finished with no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only if the log holds the pass message
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
